// ==== all.f ====
src/icache_pkg.sv
src/mem_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_fill_buffer.sv
src/icache_controller.sv
src/icache_top.sv
verification/mem_model.sv
verification/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module icache_tb -f all.f -o icache_sim

out=$(./obj_dir/icache_sim || true)
echo "$out"

if echo "$out" | grep -qxF "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// ==== verification/icache_tb.sv ====
// ----------------------------------------------------------
// Testbench for the instruction cache; runs a table of fetch,
// coherence and probe steps against a credit-based memory
// ----------------------------------------------------------
module icache_tb
    import icache_pkg::*;
    import mem_pkg::*;
();

    localparam int          wait_limit = 200;
    localparam logic [31:0] mem_seed   = 32'h0693_b51e;

    typedef enum logic [1:0] {
        k_fetch,
        k_inval,
        k_cohwr,
        k_probe
    } kind_t;

    typedef struct packed {
        kind_t        kind;
        icache_addr_u addr;
        logic         exp_miss;
        logic         exp_probe;
    } stim_t;

    logic         clk;
    logic         reset;
    fetch_req_t   fetch_req;
    logic         fetch_ready;
    fetch_rsp_t   fetch_rsp;
    mem_req_t     mem_req;
    logic         mem_req_ready;
    mem_word_t    mem_word;
    logic         mem_credit;
    coh_t         coh;
    logic         probe_valid;
    icache_addr_u probe_addr;
    logic         probe_present;

    stim_t stim_q[$];
    string name_q[$];
    int    req_count;
    int    rsp_count;
    int    credit_count;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    icache_top i_icache_top (
        .clk           (clk),
        .reset         (reset),
        .fetch_req     (fetch_req),
        .fetch_ready   (fetch_ready),
        .fetch_rsp     (fetch_rsp),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_word      (mem_word),
        .mem_credit    (mem_credit),
        .coh           (coh),
        .probe_valid   (probe_valid),
        .probe_addr    (probe_addr),
        .probe_present (probe_present)
    );

    mem_model #(
        .seed_init (mem_seed)
    ) i_mem_model (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_word      (mem_word),
        .mem_credit    (mem_credit)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // Line requests, responses and credit balance, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            credit_count = fill_depth;
            req_count    = 0;
            rsp_count    = 0;
        end else begin
            if (mem_credit) begin
                credit_count++;
                if (credit_count > fill_depth) begin
                    report_failure("Cache returned a credit for a word it never received");
                end
            end
            if (mem_word.valid) begin
                if (credit_count == 0) begin
                    report_failure("Memory sent a fill word while it held no credit");
                end
                credit_count--;
            end
            if (mem_req.valid && mem_req_ready) begin
                req_count++;
            end
            if (fetch_rsp.valid) begin
                rsp_count++;
            end
        end
    end

    // Memory content: low 16 address bits XOR a fixed pattern
    function automatic logic [word_bits-1:0] expected_word(input icache_addr_u a);
        logic [addr_bits-1:0] raw;
        raw = a;
        return raw[15:0] ^ 16'h5a5a;
    endfunction

    function automatic icache_addr_u make_addr(input int tag, input int index, input int offset);
        icache_addr_u a;
        a.f.tag    = tag_bits'(tag);
        a.f.index  = index_bits'(index);
        a.f.offset = offset_bits'(offset);
        return a;
    endfunction

    task automatic add_entry(input kind_t kind, input int tag, input int index,
                             input int offset, input logic exp_miss,
                             input logic exp_probe, input string name);
        stim_t s;
        s.kind      = kind;
        s.addr      = make_addr(tag, index, offset);
        s.exp_miss  = exp_miss;
        s.exp_probe = exp_probe;
        stim_q.push_back(s);
        name_q.push_back(name);
    endtask

    task automatic check_rsp(input string name, input fetch_rsp_t exp, input fetch_rsp_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %h, got %h", name, exp, act));
        end
    endtask

    task automatic check_miss(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("Mismatch %s: expected %0d line requests, got %0d",
                                     name, exp, act));
        end
    endtask

    task automatic check_rsp_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("Mismatch %s: expected %0d responses, got %0d",
                                     name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("Mismatch %s: expected latency %0d, got %0d",
                                     name, exp, act));
        end
    endtask

    task automatic check_probe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected probe %b, got %b", name, exp, act));
        end
    endtask

    task automatic wait_ready(input string name);
        int waited;
        waited = 0;
        while (!fetch_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                report_failure($sformatf("Timeout in %s: cache never became ready", name));
            end
        end
    endtask

    task automatic do_fetch(input string name, input icache_addr_u addr,
                            output fetch_rsp_t rsp, output int latency);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
        // Latency counts cycles after the accepting edge
        latency = 1;
        @(negedge clk);
        while (!fetch_rsp.valid) begin
            @(negedge clk);
            latency++;
            if (latency > wait_limit) begin
                report_failure($sformatf("Timeout in %s: no fetch response", name));
            end
        end
        rsp = fetch_rsp;
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_coh(input kind_t kind, input icache_addr_u addr);
        if (kind == k_inval) begin
            coh.inval_valid = 1'b1;
            coh.inval_addr  = addr;
        end else begin
            coh.wr_valid = 1'b1;
            coh.wr_addr  = addr;
        end
        @(posedge clk);
        #1;
        coh = '0;
    endtask

    task automatic sample_probe(input icache_addr_u addr, output logic present);
        probe_valid = 1'b1;
        probe_addr  = addr;
        @(negedge clk);
        present = probe_present;
        @(posedge clk);
        #1;
        probe_valid = 1'b0;
    endtask

    task automatic build_table();
        add_entry(k_fetch, 'h12, 3, 5, 1'b1, 1'b0, "cold_miss");
        for (int o = 0; o < line_words; o++) begin
            add_entry(k_fetch, 'h12, 3, o, 1'b0, 1'b0, $sformatf("line_hit_%0d", o));
        end
        add_entry(k_probe, 'h12, 3, 0, 1'b0, 1'b1, "probe_resident");
        add_entry(k_probe, 'h13, 3, 0, 1'b0, 1'b0, "probe_absent");
        // Tags A 040, B 081 and C 2c3 share index 5
        add_entry(k_fetch, 'h040, 5, 1, 1'b1, 1'b0, "lru_fill_a");
        add_entry(k_fetch, 'h081, 5, 2, 1'b1, 1'b0, "lru_fill_b");
        add_entry(k_fetch, 'h040, 5, 3, 1'b0, 1'b0, "lru_touch_a");
        add_entry(k_fetch, 'h2c3, 5, 4, 1'b1, 1'b0, "lru_fill_c");
        add_entry(k_probe, 'h081, 5, 0, 1'b0, 1'b0, "lru_b_evicted");
        add_entry(k_fetch, 'h040, 5, 5, 1'b0, 1'b0, "lru_keep_a");
        add_entry(k_fetch, 'h081, 5, 6, 1'b1, 1'b0, "lru_refetch_b");
        add_entry(k_probe, 'h2c3, 5, 0, 1'b0, 1'b0, "lru_c_evicted");
        add_entry(k_inval, 'h040, 5, 0, 1'b0, 1'b0, "inval_index");
        add_entry(k_probe, 'h040, 5, 0, 1'b0, 1'b0, "inval_a_gone");
        add_entry(k_probe, 'h081, 5, 0, 1'b0, 1'b0, "inval_b_gone");
        add_entry(k_fetch, 'h081, 5, 0, 1'b1, 1'b0, "inval_refetch_b");
        add_entry(k_fetch, 'h040, 5, 7, 1'b1, 1'b0, "inval_refetch_a");
        add_entry(k_probe, 'h040, 5, 0, 1'b0, 1'b1, "cohwr_a_before");
        add_entry(k_cohwr, 'h040, 5, 2, 1'b0, 1'b0, "cohwr_a");
        add_entry(k_probe, 'h040, 5, 0, 1'b0, 1'b0, "cohwr_a_after");
        add_entry(k_probe, 'h081, 5, 0, 1'b0, 1'b1, "cohwr_b_kept");
        add_entry(k_cohwr, 'h155, 5, 0, 1'b0, 1'b0, "cohwr_miss");
        add_entry(k_probe, 'h081, 5, 0, 1'b0, 1'b1, "cohwr_miss_kept");
        add_entry(k_fetch, 'h081, 5, 3, 1'b0, 1'b0, "cohwr_b_hit");
        add_entry(k_fetch, 'h040, 5, 2, 1'b1, 1'b0, "cohwr_a_refill");
        // Spread of lines under random memory stalls
        for (int k = 0; k < 6; k++) begin
            add_entry(k_fetch, (k * 'h0a7 + 'h31) % 1024, k * 11 + 7, k, 1'b1, 1'b0,
                      $sformatf("stress_miss_%0d", k));
            add_entry(k_fetch, (k * 'h0a7 + 'h31) % 1024, k * 11 + 7, 7 - k, 1'b0, 1'b0,
                      $sformatf("stress_hit_%0d", k));
        end
    endtask

    initial begin
        fetch_rsp_t rsp;
        fetch_rsp_t exp_rsp;
        int         latency;
        int         reqs_before;
        int         rsps_before;
        logic       present;
        reset        = 1'b1;
        fetch_req    = '0;
        coh          = '0;
        probe_valid  = 1'b0;
        probe_addr   = '0;
        req_count    = 0;
        rsp_count    = 0;
        credit_count = fill_depth;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (stim_q[i]) begin
            wait_ready(name_q[i]);
            case (stim_q[i].kind)
                k_fetch: begin
                    reqs_before = req_count;
                    rsps_before = rsp_count;
                    do_fetch(name_q[i], stim_q[i].addr, rsp, latency);
                    exp_rsp.valid = 1'b1;
                    exp_rsp.data  = expected_word(stim_q[i].addr);
                    check_rsp(name_q[i], exp_rsp, rsp);
                    wait_ready(name_q[i]);
                    check_miss(name_q[i], stim_q[i].exp_miss ? 1 : 0, req_count - reqs_before);
                    check_rsp_count(name_q[i], 1, rsp_count - rsps_before);
                    if (!stim_q[i].exp_miss) begin
                        check_latency(name_q[i], 1, latency);
                    end
                end
                k_inval, k_cohwr: begin
                    pulse_coh(stim_q[i].kind, stim_q[i].addr);
                end
                default: begin
                    sample_probe(stim_q[i].addr, present);
                    check_probe(name_q[i], stim_q[i].exp_probe, present);
                end
            endcase
        end
        wait_ready("final_drain");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verification/mem_model.sv ====
// ----------------------------------------------------------
// Behavioral line memory for the cache testbench; returns the
// words of a requested line only while it holds fill credits
// ----------------------------------------------------------
module mem_model
    import mem_pkg::*;
#(
    parameter logic [31:0] seed_init = 32'h0
) (
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  mem_req,
    output logic      mem_req_ready,
    output mem_word_t mem_word,
    input  logic      mem_credit
);

    integer                   seed;
    int                       credits;
    int                       stall;
    int                       words_left;
    logic [mem_line_bits-1:0] line_q;
    logic [2:0]               offset_q;
    logic [18:0]              word_addr;

    initial begin
        seed          = seed_init;
        credits       = fill_depth;
        stall         = 0;
        words_left    = 0;
        line_q        = '0;
        offset_q      = '0;
        word_addr     = '0;
        mem_req_ready = 1'b0;
        mem_word      = '0;
        forever begin
            @(posedge clk);
            #1;
            if (reset) begin
                credits       = fill_depth;
                words_left    = 0;
                mem_req_ready = 1'b0;
                mem_word      = '0;
            end else begin
                if (mem_credit) begin
                    credits++;
                end
                // Ready was high on the edge just passed, so the line was taken
                if (mem_req_ready) begin
                    words_left = 8;
                    offset_q   = '0;
                    stall      = $random(seed) & 3;
                end
                mem_req_ready = words_left == 0 && mem_req.valid;
                if (mem_req_ready) begin
                    line_q = mem_req.line;
                end
                mem_word = '0;
                if (words_left > 0) begin
                    if (stall > 0) begin
                        stall--;
                    end else if (credits > 0) begin
                        word_addr      = {line_q, offset_q};
                        mem_word.valid = 1'b1;
                        mem_word.data  = word_addr[15:0] ^ 16'h5a5a;
                        credits--;
                        offset_q++;
                        words_left--;
                        stall = $random(seed) & 3;
                    end
                end
            end
        end
    end

endmodule

// ==== src/icache_top.sv ====
// ----------------------------------------------------------
// Cache top level; joins the controller, tag and data stores
// and the fill buffer to the fetch, memory and coherence ports
// ----------------------------------------------------------
module icache_top
    import icache_pkg::*;
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  fetch_req_t   fetch_req,
    output logic         fetch_ready,
    output fetch_rsp_t   fetch_rsp,
    output mem_req_t     mem_req,
    input  logic         mem_req_ready,
    input  mem_word_t    mem_word,
    output logic         mem_credit,
    input  coh_t         coh,
    input  logic         probe_valid,
    input  icache_addr_u probe_addr,
    output logic         probe_present
);

    logic [num_ways-1:0]                hit;
    logic                               victim_way;
    logic [num_ways-1:0][word_bits-1:0] rd_data;
    icache_addr_u                       lookup_addr;
    logic                               lookup_en;
    logic                               fill_way;
    icache_addr_u                       fill_addr;
    logic                               fill_start;
    logic                               fill_done;
    logic                               word_valid;
    logic [word_bits-1:0]               word_data;
    logic                               word_pop;
    logic                               wr_en;
    logic                               wr_way;
    icache_addr_u                       wr_addr;
    logic [word_bits-1:0]               wr_data;

    icache_controller i_icache_controller (
        .clk           (clk),
        .reset         (reset),
        .fetch_req     (fetch_req),
        .fetch_ready   (fetch_ready),
        .fetch_rsp     (fetch_rsp),
        .hit           (hit),
        .victim_way    (victim_way),
        .rd_data       (rd_data),
        .lookup_addr   (lookup_addr),
        .lookup_en     (lookup_en),
        .fill_way      (fill_way),
        .fill_addr     (fill_addr),
        .fill_start    (fill_start),
        .fill_done     (fill_done),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .word_valid    (word_valid),
        .word_data     (word_data),
        .word_pop      (word_pop),
        .wr_en         (wr_en),
        .wr_way        (wr_way),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    icache_tag_store i_icache_tag_store (
        .clk           (clk),
        .reset         (reset),
        .lookup_addr   (lookup_addr),
        .lookup_en     (lookup_en),
        .hit           (hit),
        .victim_way    (victim_way),
        .fill_way      (fill_way),
        .fill_addr     (fill_addr),
        .fill_start    (fill_start),
        .fill_done     (fill_done),
        .coh           (coh),
        .probe_valid   (probe_valid),
        .probe_addr    (probe_addr),
        .probe_present (probe_present)
    );

    // Reads follow the lookup address so data lines up with the tags
    icache_data_store i_icache_data_store (
        .clk     (clk),
        .rd_addr (lookup_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_way  (wr_way),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    icache_fill_buffer i_icache_fill_buffer (
        .clk        (clk),
        .reset      (reset),
        .mem_word   (mem_word),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_pop   (word_pop),
        .mem_credit (mem_credit)
    );

endmodule

// ==== src/icache_controller.sv ====
// ----------------------------------------------------------
// Fetch FSM: hit check, line request on a miss, fill of all
// eight words and the single response per fetch
// ----------------------------------------------------------
module icache_controller
    import icache_pkg::*;
    import mem_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  fetch_req_t                         fetch_req,
    output logic                               fetch_ready,
    output fetch_rsp_t                         fetch_rsp,
    input  logic [num_ways-1:0]                hit,
    input  logic                               victim_way,
    input  logic [num_ways-1:0][word_bits-1:0] rd_data,
    output icache_addr_u                       lookup_addr,
    output logic                               lookup_en,
    output logic                               fill_way,
    output icache_addr_u                       fill_addr,
    output logic                               fill_start,
    output logic                               fill_done,
    output mem_req_t                           mem_req,
    input  logic                               mem_req_ready,
    input  logic                               word_valid,
    input  logic [word_bits-1:0]               word_data,
    output logic                               word_pop,
    output logic                               wr_en,
    output logic                               wr_way,
    output icache_addr_u                       wr_addr,
    output logic [word_bits-1:0]               wr_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_request,
        st_fill,
        st_reply
    } state_t;

    state_t                 state;
    icache_addr_u           req_q;
    logic                   way_q;
    logic [offset_bits-1:0] fill_cnt;
    logic                   rsp_pending;
    logic                   accept;
    logic                   last_pop;

    assign fetch_ready = state == st_idle;
    assign accept      = fetch_ready && fetch_req.valid;

    // Data RAM reads the same address; held on the request during a fill
    assign lookup_en   = accept;
    assign lookup_addr = fetch_ready ? fetch_req.addr : req_q;

    assign fill_way   = way_q;
    assign fill_addr  = req_q;
    assign fill_start = state == st_request && mem_req_ready;
    assign word_pop   = state == st_fill && word_valid;
    assign last_pop   = word_pop && fill_cnt == offset_bits'(line_words - 1);
    assign fill_done  = last_pop;

    assign mem_req.valid = state == st_request;
    assign mem_req.line  = req_q.l.line;

    assign wr_en   = word_pop;
    assign wr_way  = way_q;
    assign wr_data = word_data;

    always_comb begin
        wr_addr.l.line   = req_q.l.line;
        wr_addr.l.offset = fill_cnt;
    end

    // Hit answers from the lookup cycle, miss from the read-back
    always_comb begin
        fetch_rsp.valid = (state == st_lookup && hit != '0) || rsp_pending;
        fetch_rsp.data  = rsp_pending ? rd_data[way_q] : rd_data[hit[1]];
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= fetch_req.addr;
        end
        if (state == st_lookup) begin
            way_q <= victim_way;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= st_idle;
            fill_cnt    <= '0;
            rsp_pending <= 1'b0;
        end else begin
            rsp_pending <= word_pop && fill_cnt == req_q.l.offset;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    state <= (hit == '0) ? st_request : st_idle;
                end
                st_request: begin
                    if (mem_req_ready) begin
                        state    <= st_fill;
                        fill_cnt <= '0;
                    end
                end
                st_fill: begin
                    if (word_pop) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (last_pop) begin
                        state <= st_reply;
                    end
                end
                // Line state settles here before the next fetch
                st_reply: state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

endmodule

// ==== src/icache_fill_buffer.sv ====
// ----------------------------------------------------------
// FIFO between memory and the cache controller; every pop
// hands one credit back to the memory side
// ----------------------------------------------------------
module icache_fill_buffer
    import mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  mem_word_t                mem_word,
    output logic                     word_valid,
    output logic [mem_data_bits-1:0] word_data,
    input  logic                     word_pop,
    output logic                     mem_credit
);

    logic [mem_data_bits-1:0] fifo [fill_depth];

    logic [fill_ptr_bits-1:0] wr_ptr;
    logic [fill_ptr_bits-1:0] rd_ptr;
    logic [fill_ptr_bits:0]   count;
    logic                     push;
    logic                     pop;

    // Memory only sends with a credit in hand, so no full check
    assign push = mem_word.valid;
    assign pop  = word_pop && word_valid;

    assign word_valid = count != '0;
    assign word_data  = fifo[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= mem_word.data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            mem_credit <= 1'b0;
        end else begin
            mem_credit <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/icache_data_store.sv ====
// ----------------------------------------------------------
// Line RAMs of both ways; synchronous read of both ways and
// a single write port steered to one way
// ----------------------------------------------------------
module icache_data_store
    import icache_pkg::*;
(
    input  logic                               clk,
    input  icache_addr_u                       rd_addr,
    output logic [num_ways-1:0][word_bits-1:0] rd_data,
    input  logic                               wr_en,
    input  logic                               wr_way,
    input  icache_addr_u                       wr_addr,
    input  logic [word_bits-1:0]               wr_data
);

    localparam int ram_words = num_sets * line_words;

    logic [word_bits-1:0] ram [num_ways][ram_words];

    logic [index_bits+offset_bits-1:0] rd_ptr;
    logic [index_bits+offset_bits-1:0] wr_ptr;

    assign rd_ptr = {rd_addr.f.index, rd_addr.f.offset};
    assign wr_ptr = {wr_addr.f.index, wr_addr.f.offset};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_way][wr_ptr] <= wr_data;
        end
        for (int w = 0; w < num_ways; w++) begin
            // Write-first, so a word being filled is read back at once
            if (wr_en && wr_way == w[0] && wr_ptr == rd_ptr) begin
                rd_data[w] <= wr_data;
            end else begin
                rd_data[w] <= ram[w][rd_ptr];
            end
        end
    end

endmodule

// ==== src/icache_tag_store.sv ====
// ----------------------------------------------------------
// Tag, valid and LRU state of both ways; registered lookup,
// fill updates, coherence clears and a combinational probe
// ----------------------------------------------------------
module icache_tag_store
    import icache_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  icache_addr_u        lookup_addr,
    input  logic                lookup_en,
    output logic [num_ways-1:0] hit,
    output logic                victim_way,
    input  logic                fill_way,
    input  icache_addr_u        fill_addr,
    input  logic                fill_start,
    input  logic                fill_done,
    input  coh_t                coh,
    input  logic                probe_valid,
    input  icache_addr_u        probe_addr,
    output logic                probe_present
);

    logic [tag_bits-1:0] tag_mem [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0] valid_mem;
    logic [num_sets-1:0] lru;

    // Snapshot taken at lookup, compared one cycle later
    logic                               lookup_q;
    logic [num_ways-1:0][tag_bits-1:0] rd_tag_q;
    logic [num_ways-1:0]               rd_valid_q;
    logic [tag_bits-1:0]               look_tag_q;
    logic [index_bits-1:0]             look_idx_q;
    logic                              lru_q;

    logic [index_bits-1:0] fill_idx;
    logic [index_bits-1:0] inv_idx;
    logic [index_bits-1:0] wr_idx;
    logic [index_bits-1:0] probe_idx;
    logic [num_ways-1:0]   wr_match;
    logic                  fill_kill;
    logic                  fill_killed;

    assign fill_idx  = fill_addr.f.index;
    assign inv_idx   = coh.inval_addr.f.index;
    assign wr_idx    = coh.wr_addr.f.index;
    assign probe_idx = probe_addr.f.index;

    assign victim_way = lru_q;

    // Coherence traffic that lands on the line being filled
    assign fill_kill = (coh.inval_valid && inv_idx == fill_idx) ||
                       (coh.wr_valid && wr_idx == fill_idx &&
                        coh.wr_addr.f.tag == fill_addr.f.tag);

    always_comb begin
        probe_present = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = lookup_q && rd_valid_q[w] && rd_tag_q[w] == look_tag_q;
            wr_match[w] = coh.wr_valid && valid_mem[w][wr_idx] &&
                          tag_mem[w][wr_idx] == coh.wr_addr.f.tag;
            if (probe_valid && valid_mem[w][probe_idx] &&
                tag_mem[w][probe_idx] == probe_addr.f.tag) begin
                probe_present = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            tag_mem[fill_way][fill_idx] <= fill_addr.f.tag;
        end
        if (lookup_en) begin
            for (int w = 0; w < num_ways; w++) begin
                rd_tag_q[w]   <= tag_mem[w][lookup_addr.f.index];
                rd_valid_q[w] <= valid_mem[w][lookup_addr.f.index];
            end
            look_tag_q <= lookup_addr.f.tag;
            look_idx_q <= lookup_addr.f.index;
            lru_q      <= lru[lookup_addr.f.index];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_mem   <= '0;
            lru         <= '0;
            lookup_q    <= 1'b0;
            fill_killed <= 1'b0;
        end else begin
            lookup_q <= lookup_en;

            if (fill_start) begin
                fill_killed <= 1'b0;
            end else if (fill_kill) begin
                fill_killed <= 1'b1;
            end

            // Hit moves LRU to the other way
            if (hit != '0) begin
                lru[look_idx_q] <= hit[0];
            end

            if (fill_start) begin
                valid_mem[fill_way][fill_idx] <= 1'b0;
            end
            if (fill_done) begin
                valid_mem[fill_way][fill_idx] <= !(fill_killed || fill_kill);
                lru[fill_idx] <= ~fill_way;
            end

            // Coherence clears win over fill updates on the same edge
            for (int w = 0; w < num_ways; w++) begin
                if (coh.inval_valid) begin
                    valid_mem[w][inv_idx] <= 1'b0;
                end
                if (wr_match[w]) begin
                    valid_mem[w][wr_idx] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== src/mem_pkg.sv ====
// ----------------------------------------------------------
// Memory side of the cache: line requests, returned words and
// the credit budget of the fill path
// ----------------------------------------------------------
package mem_pkg;

    // Fill buffer depth, also the credits memory owns after reset
    localparam int fill_depth    = 4;
    localparam int fill_ptr_bits = $clog2(fill_depth);
    localparam int mem_line_bits = 16;
    localparam int mem_data_bits = 16;

    typedef struct packed {
        logic                     valid;
        logic [mem_line_bits-1:0] line;
    } mem_req_t;

    typedef struct packed {
        logic                     valid;
        logic [mem_data_bits-1:0] data;
    } mem_word_t;

endpackage

// ==== src/icache_pkg.sv ====
// ----------------------------------------------------------
// Instruction cache geometry, address views and fetch-side
// structs shared by all cache modules
// ----------------------------------------------------------
package icache_pkg;

    localparam int addr_bits   = 19;
    localparam int word_bits   = 16;
    localparam int num_sets    = 64;
    localparam int index_bits  = 6;
    localparam int line_words  = 8;
    localparam int offset_bits = 3;
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;
    localparam int num_ways    = 2;

    // Lookup and invalidation view
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } icache_addr_f_t;

    // Line view for fills and memory requests
    typedef struct packed {
        logic [tag_bits+index_bits-1:0] line;
        logic [offset_bits-1:0]         offset;
    } icache_addr_l_t;

    typedef union packed {
        icache_addr_f_t f;
        icache_addr_l_t l;
    } icache_addr_u;

    typedef struct packed {
        logic         valid;
        icache_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        logic                 valid;
        logic [word_bits-1:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic         inval_valid;
        icache_addr_u inval_addr;
        logic         wr_valid;
        icache_addr_u wr_addr;
    } coh_t;

endpackage
